/* filelist.f */
+incdir+sim
verilog/gpu_types_pkg.sv
verilog/gpu_inst_pkg.sv
verilog/inst_fifo.sv
verilog/gpu_inst_controller.sv
verilog/rect_fill.sv
verilog/gpu_core.sv
sim/tb_gpu_core.sv

/* sim/tb_gpu_model.svh */
`ifndef TB_GPU_MODEL_SVH
`define TB_GPU_MODEL_SVH

// Reference state, advanced in instruction order as each instruction is pushed.
gpu_x_t       m_x1 = '0;
gpu_y_t       m_y1 = '0;
gpu_x_t       m_x2 = '0;
gpu_y_t       m_y2 = '0;
layer_t       m_layer = LAYER_BG;
logic         m_fg_en = 1'b1;
pixel_write_t exp_q[$];
int           exp_total = 0;
logic [31:0]  lfsr_state = 32'h94bd_26e8;

// Galois LFSR, one step for each bit taken.
function automatic logic [31:0] rand_bits(input int n);
   logic [31:0] v;
   int          k;
   v = '0;
   for (k = 0; k < n; k++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
      v = {v[30:0], lfsr_state[0]};
   end
   return v;
endfunction

function automatic gpu_inst_t make_xy(input gpu_cmd_e cmd, input gpu_x_t x, input gpu_y_t y);
   gpu_inst_t i;
   i = '0;
   i.cmd = cmd;
   i.param.xy.x = x;
   i.param.xy.y = y;
   return i;
endfunction

function automatic gpu_inst_t make_attr(input gpu_cmd_e cmd, input color_t color,
                                        input layer_t lyr, input logic fg);
   gpu_inst_t i;
   i = '0;
   i.cmd = cmd;
   i.param.attr.color = color;
   i.param.attr.layer = lyr;
   i.param.attr.fg_en = fg;
   return i;
endfunction

// Any defined opcode with a fully random parameter word.
function automatic gpu_inst_t rand_inst();
   gpu_inst_t   i;
   logic [31:0] r;
   r = rand_bits(4);
   i.cmd = gpu_cmd_e'(r[3:0] % 4'd12);
   r = rand_bits(26);
   i.param = r[25:0];
   return i;
endfunction

// Min to max on both axes, x inside y.
task automatic model_fill(input color_t color, input logic clr);
   int           x;
   int           y;
   int           xl;
   int           xh;
   int           yl;
   int           yh;
   pixel_write_t p;
   xl = (m_x1 < m_x2) ? m_x1 : m_x2;
   xh = (m_x1 < m_x2) ? m_x2 : m_x1;
   yl = (m_y1 < m_y2) ? m_y1 : m_y2;
   yh = (m_y1 < m_y2) ? m_y2 : m_y1;
   for (y = yl; y <= yh; y++) begin
      for (x = xl; x <= xh; x++) begin
         p = '{x: gpu_x_t'(x), y: gpu_y_t'(y), layer: m_layer, color: color, clear: clr};
         exp_q.push_back(p);
         exp_total++;
      end
   end
endtask

task automatic model_apply(input gpu_inst_t i);
   case (i.cmd)
      CMD_SET_XY1: begin
         m_x1 = i.param.xy.x;
         m_y1 = i.param.xy.y;
      end
      CMD_SET_XY2: begin
         m_x2 = i.param.xy.x;
         m_y2 = i.param.xy.y;
      end
      CMD_DRAW_RECT: model_fill(i.param.attr.color, 1'b0);
      CMD_CLEAR: begin
         m_x1 = '0;
         m_y1 = '0;
         m_x2 = GPU_X_MAX;
         m_y2 = GPU_Y_MAX;
         m_layer = i.param.attr.layer;
         model_fill('0, 1'b1);
      end
      CMD_CLEAR_RECT: begin
         m_layer = i.param.attr.layer;
         model_fill('0, 1'b1);
      end
      CMD_SET_LAYER: m_layer = i.param.attr.layer;
      CMD_SHOW_FG: m_fg_en = i.param.attr.fg_en;
      default: begin
      end
   endcase
endtask

`endif

/* sim/tb_gpu_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_gpu_core;
   import gpu_types_pkg::*;
   import gpu_inst_pkg::*;

   localparam int SCREEN_PIXELS  = (1 << GPU_X_WIDTH) * (1 << GPU_Y_WIDTH);
   localparam int DIRECTED_INSTS = 25;
   localparam int MIX_INSTS      = 60;
   // Worst case is a full-screen fill per instruction plus issue and pop.
   localparam int TIMEOUT_CYCLES = (DIRECTED_INSTS + MIX_INSTS) * (SCREEN_PIXELS + 3) * 2;

   logic         clk;
   logic         reset;
   logic         inst_push;
   gpu_inst_t    inst;
   logic         inst_full;
   logic         pixel_valid;
   pixel_write_t pixel;
   logic         busy;
   layer_t       layer;
   logic         fg_en;

   string        cur_test = "reset";
   int           pix_count = 0;
   int           cycle_count = 0;
   int           sent;
   int           burst;
   int           k;
   pixel_write_t next_exp;
   gpu_cmd_e     dropped[5] = '{CMD_NONE, CMD_DRAW_LINE, CMD_DRAW_IMAGE, CMD_LOAD_FONT,
                                CMD_DRAW_STRING};

   `include "tb_gpu_model.svh"

   gpu_core u_dut (
      .clk         (clk),
      .reset       (reset),
      .inst_push   (inst_push),
      .inst        (inst),
      .inst_full   (inst_full),
      .pixel_valid (pixel_valid),
      .pixel       (pixel),
      .busy        (busy),
      .layer       (layer),
      .fg_en       (fg_en)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic stop_on_failure();
      $display("Test failed");
      $fatal(1, "simulation stopped on the first failure");
   endtask

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > TIMEOUT_CYCLES) begin
         $display("Timeout in %s, the run did not end within %0d cycles", cur_test,
                  TIMEOUT_CYCLES);
         stop_on_failure();
      end
   end

   function automatic string pixel_text(input pixel_write_t p);
      return $sformatf("(%0d,%0d) layer %0d color %h clear %0d", p.x, p.y, p.layer, p.color,
                       p.clear);
   endfunction

   task automatic check_pixel(input string test, input pixel_write_t expected,
                              input pixel_write_t actual);
      if (actual !== expected) begin
         $display("[ERROR] %s: pixel expected %s, actual %s", test, pixel_text(expected),
                  pixel_text(actual));
         stop_on_failure();
      end
   endtask

   task automatic check_state(input string test, input layer_t exp_layer, input logic exp_fg,
                              input layer_t act_layer, input logic act_fg);
      if (act_layer !== exp_layer || act_fg !== exp_fg) begin
         $display("[ERROR] %s: state expected layer %0d fg_en %0d, actual layer %0d fg_en %0d",
                  test, exp_layer, exp_fg, act_layer, act_fg);
         stop_on_failure();
      end
   endtask

   task automatic check_drained(input string test, input int exp_count, input int act_count);
      if (act_count !== exp_count) begin
         $display("[ERROR] %s: pixel count expected %0d, actual %0d", test, exp_count,
                  act_count);
         stop_on_failure();
      end
   endtask

   // Outputs come from registers, so the falling edge sees them settled.
   always @(negedge clk) begin
      if (!reset && pixel_valid === 1'b1) begin
         if (exp_q.size() == 0) begin
            $display("%s: pixel write %s came out with none expected", cur_test,
                     pixel_text(pixel));
            stop_on_failure();
         end else begin
            next_exp = exp_q.pop_front();
            check_pixel(cur_test, next_exp, pixel);
            pix_count++;
         end
      end
   end

   // Called on a falling edge.
   task automatic push_inst(input gpu_inst_t i);
      while (inst_full) @(negedge clk);
      inst_push = 1'b1;
      inst = i;
      model_apply(i);
      @(negedge clk);
      inst_push = 1'b0;
   endtask

   // A queued instruction raises busy the cycle after the controller goes idle,
   // so two idle samples in a row also mean the FIFO is empty.
   task automatic wait_idle();
      int idle_run;
      idle_run = 0;
      while (idle_run < 2) begin
         @(negedge clk);
         idle_run = busy ? 0 : idle_run + 1;
      end
   endtask

   task automatic finish_test();
      wait_idle();
      check_state(cur_test, m_layer, m_fg_en, layer, fg_en);
      check_drained(cur_test, exp_total, pix_count);
   endtask

   initial begin
      reset = 1'b1;
      inst_push = 1'b0;
      inst = '0;
      repeat (4) @(negedge clk);
      reset = 1'b0;
      check_state(cur_test, LAYER_BG, 1'b1, layer, fg_en);
      if (busy !== 1'b0 || inst_full !== 1'b0) begin
         $display("busy or inst_full is not low after reset");
         stop_on_failure();
      end

      cur_test = "rect_basic";
      push_inst(make_xy(CMD_SET_XY1, 4'd2, 3'd1));
      push_inst(make_xy(CMD_SET_XY2, 4'd9, 3'd5));
      push_inst(make_attr(CMD_DRAW_RECT, color_t'(rand_bits(16)), LAYER_FG, 1'b0));
      finish_test();

      // Swapped corners, a mixed order and a single pixel.
      cur_test = "rect_reversed";
      push_inst(make_xy(CMD_SET_XY1, 4'd9, 3'd5));
      push_inst(make_xy(CMD_SET_XY2, 4'd2, 3'd1));
      push_inst(make_attr(CMD_DRAW_RECT, color_t'(rand_bits(16)), LAYER_BG, 1'b1));
      push_inst(make_xy(CMD_SET_XY1, 4'd12, 3'd0));
      push_inst(make_xy(CMD_SET_XY2, 4'd5, 3'd7));
      push_inst(make_attr(CMD_DRAW_RECT, color_t'(rand_bits(16)), LAYER_BG, 1'b1));
      push_inst(make_xy(CMD_SET_XY1, 4'd7, 3'd3));
      push_inst(make_xy(CMD_SET_XY2, 4'd7, 3'd3));
      push_inst(make_attr(CMD_DRAW_RECT, color_t'(rand_bits(16)), LAYER_BG, 1'b1));
      finish_test();

      cur_test = "clear_fg";
      push_inst(make_attr(CMD_CLEAR, color_t'(rand_bits(16)), LAYER_FG, 1'b1));
      push_inst(make_attr(CMD_DRAW_RECT, color_t'(rand_bits(16)), LAYER_BG, 1'b1));
      finish_test();

      cur_test = "clear_rect";
      push_inst(make_xy(CMD_SET_XY1, 4'd3, 3'd2));
      push_inst(make_xy(CMD_SET_XY2, 4'd6, 3'd7));
      push_inst(make_attr(CMD_CLEAR_RECT, color_t'(rand_bits(16)), LAYER_BG, 1'b1));
      finish_test();

      cur_test = "register_only";
      push_inst(make_attr(CMD_SET_LAYER, color_t'(rand_bits(16)), LAYER_FG, 1'b0));
      finish_test();
      push_inst(make_attr(CMD_SHOW_FG, color_t'(rand_bits(16)), LAYER_BG, 1'b0));
      finish_test();
      for (k = 0; k < 5; k++) begin
         push_inst(make_attr(dropped[k], color_t'(rand_bits(16)), LAYER_BG, 1'b1));
      end
      finish_test();
      push_inst(make_attr(CMD_SHOW_FG, '0, LAYER_BG, 1'b1));
      finish_test();

      // Bursts longer than the FIFO stall on inst_full.
      cur_test = "random_mix";
      sent = 0;
      while (sent < MIX_INSTS) begin
         burst = 1 + rand_bits(4);
         for (k = 0; k < burst && sent < MIX_INSTS; k++) begin
            push_inst(rand_inst());
            sent++;
         end
         repeat (rand_bits(3)) @(negedge clk);
      end
      finish_test();

      $display("Test completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog/gpu_core.sv */
`timescale 1ns/1ns
`default_nettype none

module gpu_core (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        inst_push,
   input  gpu_inst_pkg::gpu_inst_t     inst,
   output logic                        inst_full,
   output logic                        pixel_valid,
   output gpu_types_pkg::pixel_write_t pixel,
   output logic                        busy,
   output gpu_types_pkg::layer_t       layer,
   output logic                        fg_en
);
   import gpu_types_pkg::*;
   import gpu_inst_pkg::*;

   gpu_inst_t fifo_head;
   logic      fifo_empty;
   logic      read_inst;

   // Controller to rectangle fill.
   gpu_x_t    x1;
   gpu_y_t    y1;
   gpu_x_t    x2;
   gpu_y_t    y2;
   color_t    fill_color;
   logic      pixel_clear;
   logic      rect_start;
   logic      rect_active;
   logic      rect_finished;

   inst_fifo u_fifo (
      .clk   (clk),
      .reset (reset),
      .push  (inst_push),
      .wdata (inst),
      .pop   (read_inst),
      .head  (fifo_head),
      .empty (fifo_empty),
      .full  (inst_full)
   );

   gpu_inst_controller u_ctrl (
      .clk           (clk),
      .reset         (reset),
      .empty         (fifo_empty),
      .inst          (fifo_head),
      .read_inst     (read_inst),
      .layer         (layer),
      .fg_en         (fg_en),
      .busy          (busy),
      .x1            (x1),
      .y1            (y1),
      .x2            (x2),
      .y2            (y2),
      .fill_color    (fill_color),
      .pixel_clear   (pixel_clear),
      .rect_start    (rect_start),
      .rect_active   (rect_active),
      .rect_finished (rect_finished)
   );

   rect_fill u_rect (
      .clk         (clk),
      .reset       (reset),
      .start       (rect_start),
      .active      (rect_active),
      .finished    (rect_finished),
      .x1          (x1),
      .y1          (y1),
      .x2          (x2),
      .y2          (y2),
      .color       (fill_color),
      .layer       (layer),
      .clear       (pixel_clear),
      .pixel_valid (pixel_valid),
      .pixel       (pixel)
   );

endmodule

`default_nettype wire

/* verilog/gpu_inst_controller.sv */
`timescale 1ns/1ns
`default_nettype none

module gpu_inst_controller (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    empty,
   input  gpu_inst_pkg::gpu_inst_t inst,
   output logic                    read_inst,
   output gpu_types_pkg::layer_t   layer,
   output logic                    fg_en,
   output logic                    busy,
   output gpu_types_pkg::gpu_x_t   x1,
   output gpu_types_pkg::gpu_y_t   y1,
   output gpu_types_pkg::gpu_x_t   x2,
   output gpu_types_pkg::gpu_y_t   y2,
   output gpu_types_pkg::color_t   fill_color,
   output logic                    pixel_clear,
   output logic                    rect_start,
   output logic                    rect_active,
   input  logic                    rect_finished
);
   import gpu_types_pkg::*;
   import gpu_inst_pkg::*;

   logic func_active_n;
   logic func_start;
   logic func_finished;
   logic start_km1;
   logic clear_cmd;
   logic rect_cmd;

   // All three fill commands run on the rectangle engine.
   assign clear_cmd = (inst.cmd == CMD_CLEAR) || (inst.cmd == CMD_CLEAR_RECT);
   assign rect_cmd  = clear_cmd || (inst.cmd == CMD_DRAW_RECT);

   // Issue the head instruction whenever nothing is in flight.
   assign func_start = func_active_n && !empty;

   always_ff @(posedge clk) begin
      if (reset) begin
         func_active_n <= 1'b1;
      end else if (func_start) begin
         func_active_n <= 1'b0;
      end else if (func_finished) begin
         func_active_n <= 1'b1;
      end
   end

   assign busy = ~func_active_n;

   // Start is held back one cycle so the fill sees the new corners.
   always_ff @(posedge clk) begin
      if (reset) begin
         start_km1   <= 1'b0;
         rect_active <= 1'b0;
      end else begin
         start_km1 <= func_start && rect_cmd;
         if (func_start && rect_cmd) begin
            rect_active <= 1'b1;
         end else if (rect_finished) begin
            rect_active <= 1'b0;
         end
      end
   end

   assign rect_start = start_km1;

   // Register-only and dropped opcodes finish in the cycle after issue.
   assign func_finished = !func_active_n && (rect_active ? rect_finished : 1'b1);

   // Pop the instruction in the same cycle it completes.
   assign read_inst = func_finished;

   always_ff @(posedge clk) begin
      if (reset) begin
         layer       <= LAYER_BG;
         fg_en       <= 1'b1;
         pixel_clear <= 1'b0;
         x1          <= '0;
         y1          <= '0;
         x2          <= '0;
         y2          <= '0;
      end else if (func_start) begin
         pixel_clear <= clear_cmd;
         case (inst.cmd)
            CMD_SET_XY1: begin
               x1 <= inst.param.xy.x;
               y1 <= inst.param.xy.y;
            end
            CMD_SET_XY2: begin
               x2 <= inst.param.xy.x;
               y2 <= inst.param.xy.y;
            end
            CMD_CLEAR: begin
               // Full-screen clear is a rectangle over the whole screen.
               x1    <= '0;
               y1    <= '0;
               x2    <= GPU_X_MAX;
               y2    <= GPU_Y_MAX;
               layer <= inst.param.attr.layer;
            end
            CMD_CLEAR_RECT: begin
               layer <= inst.param.attr.layer;
            end
            CMD_SET_LAYER: begin
               layer <= inst.param.attr.layer;
            end
            CMD_SHOW_FG: begin
               fg_en <= inst.param.attr.fg_en;
            end
            default: begin
            end
         endcase
      end
   end

   // Clears write color zero.
   always_ff @(posedge clk) begin
      if (func_start) begin
         fill_color <= clear_cmd ? '0 : inst.param.attr.color;
      end
   end

   // Only one fill may be outstanding on the engine.
   a_one_fill: assert property (@(posedge clk) disable iff (reset)
      rect_start |=> (!rect_start until_with rect_finished));

endmodule

`default_nettype wire

/* verilog/gpu_inst_pkg.sv */
`default_nettype none

package gpu_inst_pkg;

   localparam int INST_CMD_WIDTH   = 4;
   localparam int INST_PARAM_WIDTH = 26;

   // Pending instruction storage, a power of two.
   localparam int INST_FIFO_DEPTH = 8;
   localparam int INST_FIFO_AW    = $clog2(INST_FIFO_DEPTH);

   typedef enum logic [INST_CMD_WIDTH-1:0] {
      CMD_NONE        = 4'd0,
      CMD_SET_XY1     = 4'd1,
      CMD_SET_XY2     = 4'd2,
      CMD_DRAW_RECT   = 4'd3,
      CMD_DRAW_LINE   = 4'd4,
      CMD_DRAW_IMAGE  = 4'd5,
      CMD_CLEAR       = 4'd6,
      CMD_CLEAR_RECT  = 4'd7,
      CMD_SET_LAYER   = 4'd8,
      CMD_SHOW_FG     = 4'd9,
      CMD_LOAD_FONT   = 4'd10,
      CMD_DRAW_STRING = 4'd11
   } gpu_cmd_e;

   // Point parameter for the corner commands.
   typedef struct packed {
      logic [INST_PARAM_WIDTH-gpu_types_pkg::GPU_X_WIDTH-gpu_types_pkg::GPU_Y_WIDTH-1:0] pad;
      gpu_types_pkg::gpu_y_t y;
      gpu_types_pkg::gpu_x_t x;
   } inst_xy_t;

   // Attribute parameter for draw, clear and display commands.
   typedef struct packed {
      logic [INST_PARAM_WIDTH-$bits(gpu_types_pkg::color_t)-3:0] pad;
      logic                  fg_en;
      gpu_types_pkg::layer_t layer;
      gpu_types_pkg::color_t color;
   } inst_attr_t;

   typedef union packed {
      inst_xy_t   xy;
      inst_attr_t attr;
   } inst_param_u;

   typedef struct packed {
      gpu_cmd_e    cmd;
      inst_param_u param;
   } gpu_inst_t;

endpackage

`default_nettype wire

/* verilog/gpu_types_pkg.sv */
`default_nettype none

package gpu_types_pkg;

   // Screen is 16 columns by 8 rows.
   localparam int GPU_X_WIDTH = 4;
   localparam int GPU_Y_WIDTH = 3;

   typedef logic [GPU_X_WIDTH-1:0] gpu_x_t;
   typedef logic [GPU_Y_WIDTH-1:0] gpu_y_t;

   // Last column and last row.
   localparam gpu_x_t GPU_X_MAX = '1;
   localparam gpu_y_t GPU_Y_MAX = '1;

   // RGB 5:6:5.
   typedef struct packed {
      logic [4:0] r;
      logic [5:0] g;
      logic [4:0] b;
   } color_t;

   typedef logic layer_t;

   localparam layer_t LAYER_BG = 1'b0;
   localparam layer_t LAYER_FG = 1'b1;

   // One framebuffer write from the draw engine.
   typedef struct packed {
      gpu_x_t x;
      gpu_y_t y;
      layer_t layer;
      color_t color;
      logic   clear;
   } pixel_write_t;

endpackage

`default_nettype wire

/* verilog/inst_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module inst_fifo (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    push,
   input  gpu_inst_pkg::gpu_inst_t wdata,
   input  logic                    pop,
   output gpu_inst_pkg::gpu_inst_t head,
   output logic                    empty,
   output logic                    full
);
   import gpu_inst_pkg::*;

   gpu_inst_t mem [INST_FIFO_DEPTH];

   // Pointers carry one extra wrap bit to tell full from empty.
   logic [INST_FIFO_AW:0] wr_ptr;
   logic [INST_FIFO_AW:0] rd_ptr;
   logic                  do_push;
   logic                  do_pop;

   assign do_push = push && !full;
   assign do_pop  = pop && !empty;

   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[INST_FIFO_AW] != rd_ptr[INST_FIFO_AW]) &&
                  (wr_ptr[INST_FIFO_AW-1:0] == rd_ptr[INST_FIFO_AW-1:0]);

   // Show-ahead output.
   assign head = mem[rd_ptr[INST_FIFO_AW-1:0]];

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr[INST_FIFO_AW-1:0]] <= wdata;
      end
   end

   // The host must honour full.
   a_no_push_full: assert property (@(posedge clk) disable iff (reset)
      !(push && full));

   // The controller only pops an instruction it has issued.
   a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
      !(pop && empty));

endmodule

`default_nettype wire

/* verilog/rect_fill.sv */
`timescale 1ns/1ns
`default_nettype none

module rect_fill (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        start,
   input  logic                        active,
   output logic                        finished,
   input  gpu_types_pkg::gpu_x_t       x1,
   input  gpu_types_pkg::gpu_y_t       y1,
   input  gpu_types_pkg::gpu_x_t       x2,
   input  gpu_types_pkg::gpu_y_t       y2,
   input  gpu_types_pkg::color_t       color,
   input  gpu_types_pkg::layer_t       layer,
   input  logic                        clear,
   output logic                        pixel_valid,
   output gpu_types_pkg::pixel_write_t pixel
);
   import gpu_types_pkg::*;

   gpu_x_t x_min;
   gpu_x_t x_max;
   gpu_y_t y_min;
   gpu_y_t y_max;
   gpu_x_t x_lo;
   gpu_x_t x_hi;
   gpu_y_t y_hi;
   gpu_x_t cur_x;
   gpu_y_t cur_y;
   logic   scanning;
   logic   last_col;
   logic   last_pixel;

   // Corners may arrive in either order.
   assign x_min = (x1 < x2) ? x1 : x2;
   assign x_max = (x1 < x2) ? x2 : x1;
   assign y_min = (y1 < y2) ? y1 : y2;
   assign y_max = (y1 < y2) ? y2 : y1;

   assign last_col   = (cur_x == x_hi);
   assign last_pixel = last_col && (cur_y == y_hi);

   always_ff @(posedge clk) begin
      if (reset) begin
         scanning <= 1'b0;
         finished <= 1'b0;
      end else begin
         finished <= scanning && active && last_pixel;
         if (start) begin
            scanning <= 1'b1;
         end else if (!active || last_pixel) begin
            // The controller dropping active aborts the fill.
            scanning <= 1'b0;
         end
      end
   end

   // Raster order, x inside y.
   always_ff @(posedge clk) begin
      if (start) begin
         x_lo  <= x_min;
         x_hi  <= x_max;
         y_hi  <= y_max;
         cur_x <= x_min;
         cur_y <= y_min;
      end else if (scanning) begin
         if (last_col) begin
            cur_x <= x_lo;
            cur_y <= cur_y + 1'b1;
         end else begin
            cur_x <= cur_x + 1'b1;
         end
      end
   end

   assign pixel_valid = scanning;
   assign pixel = '{x: cur_x, y: cur_y, layer: layer, color: color, clear: clear};

   // Writes only leave while the controller holds the fill active.
   a_valid_in_active: assert property (@(posedge clk) disable iff (reset)
      pixel_valid |-> active);

endmodule

`default_nettype wire
